/* Makefile */
TOP = tb_llink_write_slave

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

/* dv/llink_write_slave_properties.sv */
// Protocol checks for one receive FIFO, bound into every instance
// The FIFO head and head_valid act as the valid/payload pair
// Reset is synchronous, so checks start one edge after it

`timescale 1ns/100ps

module llink_write_slave_properties #(
  parameter type payload_t = logic [7:0]
) (
  input logic     clk_wr,
  input logic     reset,
  input logic     pop,
  input payload_t head,
  input logic     head_valid
);

  ////////////////////
  // Valid rules

  // Nothing valid right after a reset edge
  no_valid_in_reset: assert property (@(posedge clk_wr) reset |=> !head_valid)
    else $error("FIFO head valid right after reset");

  // Head stays put until it is taken
  head_held: assert property (@(posedge clk_wr) disable iff (reset)
    head_valid && !pop |=> head_valid && $stable(head))
    else $error("FIFO head changed or dropped without a pop");

  ////////////////////
  // Pop rules

  no_pop_when_empty: assert property (@(posedge clk_wr) disable iff (reset)
    pop |-> head_valid)
    else $error("Pop while the FIFO head is not valid");

endmodule

/* dv/tb_llink_write_slave.sv */
// Drives the link partner and a user slave with seeded random ready
// Partner starts with the default depths as credits, tx_online stays high
// Stops at the first mismatch, or after 4000 cycles

`timescale 1ns/100ps

module tb_llink_write_slave
  import llink_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 4000;

  logic    clk_wr;
  logic    reset;
  logic    tx_online;
  logic    rx_online;
  rx_phy_t rx_phy;
  tx_phy_t tx_phy;
  aw_pkt_t user_aw;
  logic    user_awvalid;
  logic    user_awready;
  w_pkt_t  user_w;
  logic    user_wvalid;
  logic    user_wready;
  logic    aw_overflow;
  logic    w_overflow;

  // Partner and user-side bookkeeping
  aw_pkt_t     aw_send_q[$];
  w_pkt_t      w_send_q[$];
  aw_pkt_t     aw_exp_q[$];
  w_pkt_t      w_exp_q[$];
  logic [31:0] rng;
  int          aw_credits;
  int          w_credits;
  int          aw_credit_total;
  int          w_credit_total;
  int          aw_acc;
  int          w_acc;
  int          last_acc;
  bit          rand_ready;
  bit          over_credit;

  llink_write_slave_top #(
    .AW_DEPTH (AW_DEPTH_DEF),
    .W_DEPTH  (W_DEPTH_DEF)
  ) dut (.*);

  bind credit_rx_fifo llink_write_slave_properties #(.payload_t(payload_t)) u_props (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .pop        (pop),
    .head       (head),
    .head_valid (head_valid)
  );

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  ////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // W may only be offered while an accepted AW still lacks its last beat
  function automatic logic expected_w_gate(input int aw_done, input int last_done);
    return aw_done > last_done;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_aw(input string name, input aw_pkt_t exp, input aw_pkt_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_w(input string name, input w_pkt_t exp, input w_pkt_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      stop_with_error($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
  endtask

  // Random bursts of 1 to 4 beats, W optional
  task automatic queue_bursts(input int n, input bit with_w);
    aw_pkt_t aw;
    w_pkt_t  w;
    for (int b = 0; b < n; b++) begin
      rng = lcg_next(rng);
      aw.id    = rng[31:28];
      aw.len   = LEN_W'(rng[25:24]);
      aw.size  = 3'd2;
      aw.burst = 2'b01;
      rng = lcg_next(rng);
      aw.addr = {rng[31:2], 2'b00};
      aw_send_q.push_back(aw);
      for (int i = 0; with_w && i <= int'(aw.len); i++) begin
        rng = lcg_next(rng);
        w.id   = aw.id;
        w.data = rng;
        w.strb = rng[19:16];
        w.last = (i == int'(aw.len));
        w_send_q.push_back(w);
      end
    end
  endtask

  // One clock of the partner and user models, inputs driven 1 ns after the edge
  task automatic partner_cycle();
    rx_phy_t phy;
    @(posedge clk_wr);
    #1;
    phy = '0;
    if (tx_phy.aw_credit) begin
      aw_credits++;
      aw_credit_total++;
    end
    if (tx_phy.w_credit) begin
      w_credits++;
      w_credit_total++;
    end
    if (aw_credits > AW_DEPTH_DEF || w_credits > W_DEPTH_DEF) begin
      stop_with_error("Partner got back more credits than it spent");
    end
    if (rand_ready) begin
      rng = lcg_next(rng);
      user_awready = rng[30];
      user_wready  = rng[29] | rng[27];
    end
    if (aw_send_q.size() > 0 && (aw_credits > 0 || over_credit || !rx_online)) begin
      phy.aw_pkt  = aw_send_q.pop_front();
      phy.aw_push = 1'b1;
      if (rx_online && aw_credits > 0) begin
        aw_credits--;
        aw_exp_q.push_back(phy.aw_pkt);
      end
    end
    if (w_send_q.size() > 0 && (w_credits > 0 || !rx_online)) begin
      phy.w_pkt  = w_send_q.pop_front();
      phy.w_push = 1'b1;
      if (rx_online) begin
        w_credits--;
        w_exp_q.push_back(phy.w_pkt);
      end
    end
    rx_phy = phy;
  endtask

  task automatic drain_sends();
    while (aw_send_q.size() > 0 || w_send_q.size() > 0) begin
      partner_cycle();
    end
    repeat (4) partner_cycle();
  endtask

  ////////////////////
  // Compare at the falling edge, where all DUT outputs have settled

  always @(negedge clk_wr) begin
    if (!reset) begin
      if (!expected_w_gate(aw_acc, last_acc)) begin
        check_flag("w_gate", 1'b0, user_wvalid);
      end
      if (user_awvalid && user_awready) begin
        if (aw_exp_q.size() == 0) begin
          stop_with_error("AW transfer at the user port with no AW packet pending");
        end else begin
          check_aw("aw_order", aw_exp_q.pop_front(), user_aw);
          aw_acc++;
        end
      end
      if (user_wvalid && user_wready) begin
        if (w_exp_q.size() == 0) begin
          stop_with_error("W transfer at the user port with no W beat pending");
        end else begin
          check_w("w_order", w_exp_q.pop_front(), user_w);
          w_acc++;
          last_acc += int'(user_w.last);
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk_wr);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        stop_with_error("Timeout, the run did not finish within 4000 cycles");
      end
    end
  end

  ////////////////////
  // Test sequence

  initial begin
    rng = 32'hf163;
    reset = 1'b1;
    tx_online = 1'b1;
    rx_online = 1'b1;
    rx_phy = '0;
    user_awready = 1'b0;
    user_wready = 1'b0;
    aw_credits = AW_DEPTH_DEF;
    w_credits = W_DEPTH_DEF;
    aw_credit_total = 0;
    w_credit_total = 0;
    aw_acc = 0;
    w_acc = 0;
    last_acc = 0;
    rand_ready = 1'b0;
    over_credit = 1'b0;
    repeat (3) @(posedge clk_wr);
    #1;
    reset = 1'b0;

    // W must wait while no AW is accepted
    user_wready = 1'b1;
    queue_bursts(3, 1'b1);
    repeat (30) partner_cycle();
    check_flag("w_held", 1'b0, user_wvalid);

    // Random ready against full-rate pushes within credit
    rand_ready = 1'b1;
    queue_bursts(40, 1'b1);
    while (aw_send_q.size() > 0 || w_send_q.size() > 0 ||
           aw_exp_q.size() > 0 || w_exp_q.size() > 0) begin
      partner_cycle();
    end
    repeat (4) partner_cycle();
    rand_ready = 1'b0;
    if (aw_credit_total != aw_acc || w_credit_total != w_acc) begin
      stop_with_error("Credit pulses do not match the user transfers");
    end
    if (aw_credits != AW_DEPTH_DEF || w_credits != W_DEPTH_DEF) begin
      stop_with_error("Partner did not get all of its credits back");
    end
    check_flag("aw_overflow_random", 1'b0, aw_overflow);
    check_flag("w_overflow_random", 1'b0, w_overflow);

    // Pushes while the receive side is down are dropped
    rx_online = 1'b0;
    user_awready = 1'b1;
    user_wready = 1'b1;
    queue_bursts(2, 1'b1);
    drain_sends();
    check_flag("offline_awvalid", 1'b0, user_awvalid);
    check_flag("offline_wvalid", 1'b0, user_wvalid);
    rx_online = 1'b1;

    // Fill the AW FIFO, then one push beyond credit
    user_awready = 1'b0;
    queue_bursts(AW_DEPTH_DEF, 1'b0);
    drain_sends();
    check_flag("aw_overflow_full", 1'b0, aw_overflow);
    over_credit = 1'b1;
    queue_bursts(1, 1'b0);
    drain_sends();
    over_credit = 1'b0;
    check_flag("aw_overflow", 1'b1, aw_overflow);
    check_flag("w_overflow", 1'b0, w_overflow);

    // The stored packets still come out intact, the extra one is gone
    user_awready = 1'b1;
    while (aw_exp_q.size() > 0) begin
      partner_cycle();
    end
    repeat (4) partner_cycle();
    check_flag("aw_drained", 1'b0, user_awvalid);

    $display("Simulation passed");
    $finish;
  end

endmodule

/* hdl/axi_write_issuer.sv */
// User-side AW and W channels driven from the FIFO heads
// W beats are held until the AW of their burst has been accepted
// Bursts are assumed to arrive in the same order on AW and W
// AW is held back while the outstanding burst counter is saturated

`timescale 1ns/100ps

module axi_write_issuer
  import llink_pkg::*;
(
  input  logic    clk_wr,
  input  logic    reset,

  // FIFO heads
  input  aw_pkt_t aw_head,
  input  logic    aw_head_valid,
  input  w_pkt_t  w_head,
  input  logic    w_head_valid,

  // FIFO pops
  output logic    aw_pop,
  output logic    w_pop,

  // User AW channel
  output aw_pkt_t user_aw,
  output logic    user_awvalid,
  input  logic    user_awready,

  // User W channel
  output w_pkt_t  user_w,
  output logic    user_wvalid,
  input  logic    user_wready
);

  localparam int OUTST_W = 8;

  // Accepted AWs whose last beat has not yet gone out
  logic [OUTST_W-1:0] outst;
  logic               outst_full;
  logic               aw_hs;
  logic               w_hs;
  logic               last_hs;

  assign outst_full = &outst;

  ////////////////////
  // Channel gating

  assign user_aw      = aw_head;
  assign user_awvalid = aw_head_valid & ~outst_full;

  // W only flows for a burst the user already knows about
  assign user_w       = w_head;
  assign user_wvalid  = w_head_valid & (outst != '0);

  assign aw_hs   = user_awvalid & user_awready;
  assign w_hs    = user_wvalid & user_wready;
  assign last_hs = w_hs & w_head.last;

  // A pop is exactly a user transfer
  assign aw_pop = aw_hs;
  assign w_pop  = w_hs;

  ////////////////////
  // Outstanding bursts

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      outst <= '0;
    end else begin
      case ({aw_hs, last_hs})
        2'b10:   outst <= outst + OUTST_W'(1);
        2'b01:   outst <= outst - OUTST_W'(1);
        default: outst <= outst;
      endcase
    end
  end

endmodule

/* hdl/credit_rx_fifo.sv */
// Receive FIFO for one link channel, payload set by a type parameter
// A push into a full FIFO is discarded and sets the sticky overflow flag
// Overflow only clears on reset
// DEPTH need not be a power of two

`timescale 1ns/100ps

module credit_rx_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk_wr,
  input  logic     reset,

  // Write side
  input  logic     push,
  input  payload_t push_data,

  // Read side
  input  logic     pop,
  output payload_t head,
  output logic     head_valid,

  // Credit return and status
  output logic     pop_credit,
  output logic     overflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr;
  logic     [PTR_W-1:0] rd_ptr;
  logic     [CNT_W-1:0] count;
  logic                 full;
  logic                 push_ok;
  logic                 pop_ok;

  // Pointer step with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + PTR_W'(1);
    end
    return nxt;
  endfunction

  assign full       = (count == CNT_W'(DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  assign push_ok    = push & ~full;
  assign pop_ok     = pop & head_valid;

  // Each pop hands one credit back to the partner
  assign pop_credit = pop_ok;

  ////////////////////
  // Pointers and occupancy

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop_ok) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  ////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

/* hdl/link_unpacker.sv */
// PHY boundary of the receive link, one register stage in each direction
// Push bits are dropped while rx_online is low
// Credits earned while tx_online is low are lost, not queued
// Packet payload registers carry no reset

`timescale 1ns/100ps

module link_unpacker
  import llink_pkg::*;
(
  input  logic    clk_wr,
  input  logic    reset,

  // Link state
  input  logic    rx_online,
  input  logic    tx_online,

  // Incoming PHY word
  input  rx_phy_t rx_phy,

  // Credit pulses from the FIFOs
  input  logic    aw_credit,
  input  logic    w_credit,

  // Push side of the FIFOs
  output logic    aw_push,
  output logic    w_push,
  output aw_pkt_t aw_push_pkt,
  output w_pkt_t  w_push_pkt,

  // Outgoing PHY word
  output tx_phy_t tx_phy
);

  ////////////////////
  // Receive direction

  // Push strobes only count while the receive side is up
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      aw_push <= 1'b0;
      w_push  <= 1'b0;
    end else begin
      aw_push <= rx_online & rx_phy.aw_push;
      w_push  <= rx_online & rx_phy.w_push;
    end
  end

  always_ff @(posedge clk_wr) begin
    aw_push_pkt <= rx_phy.aw_pkt;
    w_push_pkt  <= rx_phy.w_pkt;
  end

  ////////////////////
  // Transmit direction

  // One registered credit pulse per popped packet
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy <= '0;
    end else begin
      tx_phy.aw_credit <= tx_online & aw_credit;
      tx_phy.w_credit  <= tx_online & w_credit;
    end
  end

endmodule

/* hdl/llink_pkg.sv */
// Shared widths and packet layouts for the receive link
// Data path is fixed at 32 bits with 4 strobe bits
// One AW packet and one W packet fit in a single PHY word
// Default depths are also the credits the link partner starts with

package llink_pkg;

  ////////////////////
  // Field widths

  localparam int ID_W    = 4;
  localparam int ADDR_W  = 32;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;

  ////////////////////
  // Channel packets

  // Write address, 49 bits
  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
  } aw_pkt_t;

  // Write data beat, 41 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_pkt_t;

  ////////////////////
  // PHY words

  // Received from the partner, 92 bits
  typedef struct packed {
    w_pkt_t  w_pkt;
    aw_pkt_t aw_pkt;
    logic    w_push;
    logic    aw_push;
  } rx_phy_t;

  // Sent back to the partner, one credit pulse per channel
  typedef struct packed {
    logic aw_credit;
    logic w_credit;
  } tx_phy_t;

  ////////////////////
  // Default FIFO depths

  localparam int AW_DEPTH_DEF = 8;
  localparam int W_DEPTH_DEF  = 16;

endpackage

/* hdl/llink_write_slave_top.sv */
// Receive half of a credit-based link for an AXI-style write slave
// Only AW and W are carried, 32-bit data with 4 strobe bits
// The partner must start with AW_DEPTH and W_DEPTH credits
// Push to credit latency is two cycles through the PHY registers

`timescale 1ns/100ps

module llink_write_slave_top
  import llink_pkg::*;
#(
  parameter int AW_DEPTH = AW_DEPTH_DEF,
  parameter int W_DEPTH  = W_DEPTH_DEF
) (
  input  logic    clk_wr,
  input  logic    reset,

  // Link state
  input  logic    tx_online,
  input  logic    rx_online,

  // PHY words
  input  rx_phy_t rx_phy,
  output tx_phy_t tx_phy,

  // User AW channel
  output aw_pkt_t user_aw,
  output logic    user_awvalid,
  input  logic    user_awready,

  // User W channel
  output w_pkt_t  user_w,
  output logic    user_wvalid,
  input  logic    user_wready,

  // Sticky status
  output logic    aw_overflow,
  output logic    w_overflow
);

  ////////////////////
  // Interconnect

  logic    aw_push;
  logic    w_push;
  aw_pkt_t aw_push_pkt;
  w_pkt_t  w_push_pkt;
  aw_pkt_t aw_head;
  w_pkt_t  w_head;
  logic    aw_head_valid;
  logic    w_head_valid;
  logic    aw_pop;
  logic    w_pop;
  logic    aw_credit;
  logic    w_credit;

  ////////////////////
  // PHY boundary

  link_unpacker u_unpacker (
    .clk_wr      (clk_wr),
    .reset       (reset),
    .rx_online   (rx_online),
    .tx_online   (tx_online),
    .rx_phy      (rx_phy),
    .aw_credit   (aw_credit),
    .w_credit    (w_credit),
    .aw_push     (aw_push),
    .w_push      (w_push),
    .aw_push_pkt (aw_push_pkt),
    .w_push_pkt  (w_push_pkt),
    .tx_phy      (tx_phy)
  );

  ////////////////////
  // Channel buffers

  credit_rx_fifo #(
    .payload_t (aw_pkt_t),
    .DEPTH     (AW_DEPTH)
  ) u_aw_fifo (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .push       (aw_push),
    .push_data  (aw_push_pkt),
    .pop        (aw_pop),
    .head       (aw_head),
    .head_valid (aw_head_valid),
    .pop_credit (aw_credit),
    .overflow   (aw_overflow)
  );

  credit_rx_fifo #(
    .payload_t (w_pkt_t),
    .DEPTH     (W_DEPTH)
  ) u_w_fifo (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .push       (w_push),
    .push_data  (w_push_pkt),
    .pop        (w_pop),
    .head       (w_head),
    .head_valid (w_head_valid),
    .pop_credit (w_credit),
    .overflow   (w_overflow)
  );

  ////////////////////
  // User side

  axi_write_issuer u_issuer (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .aw_head       (aw_head),
    .aw_head_valid (aw_head_valid),
    .w_head        (w_head),
    .w_head_valid  (w_head_valid),
    .aw_pop        (aw_pop),
    .w_pop         (w_pop),
    .user_aw       (user_aw),
    .user_awvalid  (user_awvalid),
    .user_awready  (user_awready),
    .user_w        (user_w),
    .user_wvalid   (user_wvalid),
    .user_wready   (user_wready)
  );

endmodule

/* list.f */
hdl/llink_pkg.sv
hdl/link_unpacker.sv
hdl/credit_rx_fifo.sv
hdl/axi_write_issuer.sv
hdl/llink_write_slave_top.sv
dv/llink_write_slave_properties.sv
dv/tb_llink_write_slave.sv
